//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int DATA_W = 8;
	localparam int ADDR_W = 16;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ADDR_W-1:0] addr_t;
	// Bit index into the status byte
	typedef logic [2:0] flag_sel_t;

	localparam addr_t RESET_PC = 16'h0200;

	localparam flag_sel_t STATUS_C = 3'd0;
	localparam flag_sel_t STATUS_Z = 3'd1;
	localparam flag_sel_t STATUS_R = 3'd5;
	localparam flag_sel_t STATUS_V = 3'd6;
	localparam flag_sel_t STATUS_N = 3'd7;

	typedef enum logic [2:0] {
		ALU_ADC, ALU_SBC, ALU_AND, ALU_OR, ALU_XOR, ALU_INC, ALU_DEC, ALU_PASS
	} alu_func_t;

	typedef enum logic [3:0] {
		CLS_LOAD, CLS_STORE, CLS_ALU, CLS_INCDEC, CLS_TRANSFER,
		CLS_FLAG, CLS_BRANCH, CLS_JUMP, CLS_HALT, CLS_ILLEGAL
	} op_class_t;

	typedef enum logic [1:0] {
		AM_IMPLIED, AM_IMMEDIATE, AM_ABSOLUTE, AM_RELATIVE
	} addr_mode_t;

	typedef enum logic [1:0] {
		REG_A, REG_X, REG_Y
	} reg_sel_t;

	typedef enum logic [2:0] {
		S_FETCH, S_DECODE, S_OPER_LO, S_OPER_HI, S_EXEC, S_WRITE, S_HALTED
	} seq_state_t;

	// Opcodes of the supported subset
	localparam data_t OP_LDA_IMM = 8'hA9;
	localparam data_t OP_LDA_ABS = 8'hAD;
	localparam data_t OP_LDX_IMM = 8'hA2;
	localparam data_t OP_LDX_ABS = 8'hAE;
	localparam data_t OP_LDY_IMM = 8'hA0;
	localparam data_t OP_LDY_ABS = 8'hAC;
	localparam data_t OP_STA_ABS = 8'h8D;
	localparam data_t OP_STX_ABS = 8'h8E;
	localparam data_t OP_STY_ABS = 8'h8C;
	localparam data_t OP_ADC_IMM = 8'h69;
	localparam data_t OP_ADC_ABS = 8'h6D;
	localparam data_t OP_SBC_IMM = 8'hE9;
	localparam data_t OP_SBC_ABS = 8'hED;
	localparam data_t OP_AND_IMM = 8'h29;
	localparam data_t OP_AND_ABS = 8'h2D;
	localparam data_t OP_ORA_IMM = 8'h09;
	localparam data_t OP_ORA_ABS = 8'h0D;
	localparam data_t OP_EOR_IMM = 8'h49;
	localparam data_t OP_EOR_ABS = 8'h4D;
	localparam data_t OP_INX = 8'hE8;
	localparam data_t OP_INY = 8'hC8;
	localparam data_t OP_DEX = 8'hCA;
	localparam data_t OP_DEY = 8'h88;
	localparam data_t OP_TAX = 8'hAA;
	localparam data_t OP_TXA = 8'h8A;
	localparam data_t OP_TAY = 8'hA8;
	localparam data_t OP_TYA = 8'h98;
	localparam data_t OP_CLC = 8'h18;
	localparam data_t OP_SEC = 8'h38;
	localparam data_t OP_BEQ = 8'hF0;
	localparam data_t OP_BNE = 8'hD0;
	localparam data_t OP_BCC = 8'h90;
	localparam data_t OP_BCS = 8'hB0;
	localparam data_t OP_JMP_ABS = 8'h4C;
	localparam data_t OP_BRK = 8'h00;

endpackage

`default_nettype wire

//--- rtl/alu.sv
`default_nettype none
`timescale 1ns/100ps

module alu (
	input  cpu_pkg::alu_func_t func_i,
	input  cpu_pkg::data_t     a_i,
	input  cpu_pkg::data_t     b_i,
	input  logic               carry_i,
	output cpu_pkg::data_t     result_o,
	output logic               carry_o,
	output logic               ovf_o,
	output logic               sign_o,
	output logic               zero_o
);
	import cpu_pkg::*;

	data_t b_eff;
	logic [DATA_W:0] sum;

	// 6502 subtract is an add of the inverted operand
	assign b_eff = (func_i == ALU_SBC) ? ~b_i : b_i;
	assign sum = {1'b0, a_i} + {1'b0, b_eff} + {{DATA_W{1'b0}}, carry_i};

	always_comb begin
		result_o = a_i;
		carry_o = carry_i;
		ovf_o = 1'b0;
		case (func_i)
			ALU_ADC, ALU_SBC: begin
				result_o = sum[DATA_W-1:0];
				carry_o = sum[DATA_W];
				// Operands agree in sign but the result does not
				ovf_o = (a_i[DATA_W-1] == b_eff[DATA_W-1]) &&
					(sum[DATA_W-1] != a_i[DATA_W-1]);
			end
			ALU_AND: result_o = a_i & b_i;
			ALU_OR: result_o = a_i | b_i;
			ALU_XOR: result_o = a_i ^ b_i;
			ALU_INC: result_o = a_i + b_i;
			ALU_DEC: result_o = a_i - b_i;
			default: result_o = a_i;
		endcase
	end

	assign sign_o = result_o[DATA_W-1];
	assign zero_o = (result_o == '0);

endmodule

`default_nettype wire

//--- rtl/cpu_regs.sv
`default_nettype none
`timescale 1ns/100ps

module cpu_regs (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  cpu_pkg::reg_sel_t reg_sel_i,
	input  logic              reg_we_i,
	input  cpu_pkg::data_t    reg_data_i,
	input  logic              status_we_i,
	input  logic              carry_we_i,
	input  logic              ovf_we_i,
	input  logic              carry_i,
	input  logic              ovf_i,
	input  logic              sign_i,
	input  logic              zero_i,
	input  logic              clc_i,
	input  logic              sec_i,
	output cpu_pkg::data_t    a_o,
	output cpu_pkg::data_t    x_o,
	output cpu_pkg::data_t    y_o,
	output cpu_pkg::data_t    status_o
);
	import cpu_pkg::*;

	data_t status_q;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			a_o <= '0;
			x_o <= '0;
			y_o <= '0;
		end else if (reg_we_i) begin
			case (reg_sel_i)
				REG_X: x_o <= reg_data_i;
				REG_Y: y_o <= reg_data_i;
				default: a_o <= reg_data_i;
			endcase
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			status_q <= '0;
		end else begin
			// N and Z follow every register write
			if (reg_we_i) begin
				status_q[STATUS_N] <= sign_i;
				status_q[STATUS_Z] <= zero_i;
			end
			if (status_we_i && ovf_we_i)
				status_q[STATUS_V] <= ovf_i;
			if (clc_i)
				status_q[STATUS_C] <= 1'b0;
			else if (sec_i)
				status_q[STATUS_C] <= 1'b1;
			else if (status_we_i && carry_we_i)
				status_q[STATUS_C] <= carry_i;
		end
	end

	// Reserved bit reads as one
	always_comb begin
		status_o = status_q;
		status_o[STATUS_R] = 1'b1;
	end

endmodule

`default_nettype wire

//--- rtl/pc.sv
`default_nettype none
`timescale 1ns/100ps

module pc (
	input  logic           clk_i,
	input  logic           rst_n_i,
	input  logic           inc_i,
	input  logic           load_i,
	input  cpu_pkg::addr_t load_addr_i,
	input  logic           branch_i,
	input  cpu_pkg::data_t offset_i,
	output cpu_pkg::addr_t pc_o
);
	import cpu_pkg::*;

	addr_t offset_ext;

	// Branch offset is signed
	assign offset_ext = {{(ADDR_W-DATA_W){offset_i[DATA_W-1]}}, offset_i};

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			pc_o <= RESET_PC;
		else if (load_i)
			pc_o <= load_addr_i;
		else if (branch_i)
			pc_o <= pc_o + offset_ext;
		else if (inc_i)
			pc_o <= pc_o + addr_t'(1);
	end

endmodule

`default_nettype wire

//--- rtl/idec.sv
`default_nettype none
`timescale 1ns/100ps

module idec (
	input  cpu_pkg::data_t      ir_i,
	output cpu_pkg::op_class_t  op_class_o,
	output cpu_pkg::alu_func_t  alu_func_o,
	output cpu_pkg::reg_sel_t   reg_sel_o,
	output cpu_pkg::reg_sel_t   src_sel_o,
	output cpu_pkg::addr_mode_t addr_mode_o,
	output cpu_pkg::flag_sel_t  branch_flag_o,
	output logic                branch_val_o,
	output logic                sets_cv_o
);
	import cpu_pkg::*;

	always_comb begin
		case (ir_i)
			OP_LDA_IMM, OP_LDA_ABS, OP_LDX_IMM, OP_LDX_ABS, OP_LDY_IMM, OP_LDY_ABS:
				op_class_o = CLS_LOAD;
			OP_STA_ABS, OP_STX_ABS, OP_STY_ABS:
				op_class_o = CLS_STORE;
			OP_ADC_IMM, OP_ADC_ABS, OP_SBC_IMM, OP_SBC_ABS, OP_AND_IMM, OP_AND_ABS,
			OP_ORA_IMM, OP_ORA_ABS, OP_EOR_IMM, OP_EOR_ABS:
				op_class_o = CLS_ALU;
			OP_INX, OP_INY, OP_DEX, OP_DEY: op_class_o = CLS_INCDEC;
			OP_TAX, OP_TXA, OP_TAY, OP_TYA: op_class_o = CLS_TRANSFER;
			OP_CLC, OP_SEC: op_class_o = CLS_FLAG;
			OP_BEQ, OP_BNE, OP_BCC, OP_BCS: op_class_o = CLS_BRANCH;
			OP_JMP_ABS: op_class_o = CLS_JUMP;
			OP_BRK: op_class_o = CLS_HALT;
			default: op_class_o = CLS_ILLEGAL;
		endcase
	end

	always_comb begin
		if (ir_i inside {OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_ADC_IMM, OP_SBC_IMM,
				OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM})
			addr_mode_o = AM_IMMEDIATE;
		else if (op_class_o inside {CLS_LOAD, CLS_STORE, CLS_ALU, CLS_JUMP})
			addr_mode_o = AM_ABSOLUTE;
		else if (op_class_o == CLS_BRANCH)
			addr_mode_o = AM_RELATIVE;
		else
			addr_mode_o = AM_IMPLIED;
	end

	// Destination register, or the source of a store
	always_comb begin
		if (ir_i inside {OP_LDX_IMM, OP_LDX_ABS, OP_STX_ABS, OP_INX, OP_DEX, OP_TAX})
			reg_sel_o = REG_X;
		else if (ir_i inside {OP_LDY_IMM, OP_LDY_ABS, OP_STY_ABS, OP_INY, OP_DEY, OP_TAY})
			reg_sel_o = REG_Y;
		else
			reg_sel_o = REG_A;
	end

	always_comb begin
		if (ir_i inside {OP_INX, OP_DEX, OP_TXA})
			src_sel_o = REG_X;
		else if (ir_i inside {OP_INY, OP_DEY, OP_TYA})
			src_sel_o = REG_Y;
		else
			src_sel_o = REG_A;
	end

	always_comb begin
		case (ir_i)
			OP_ADC_IMM, OP_ADC_ABS: alu_func_o = ALU_ADC;
			OP_SBC_IMM, OP_SBC_ABS: alu_func_o = ALU_SBC;
			OP_AND_IMM, OP_AND_ABS: alu_func_o = ALU_AND;
			OP_ORA_IMM, OP_ORA_ABS: alu_func_o = ALU_OR;
			OP_EOR_IMM, OP_EOR_ABS: alu_func_o = ALU_XOR;
			OP_INX, OP_INY: alu_func_o = ALU_INC;
			OP_DEX, OP_DEY: alu_func_o = ALU_DEC;
			default: alu_func_o = ALU_PASS;
		endcase
	end

	// Flag value also serves CLC and SEC
	assign branch_flag_o = (ir_i inside {OP_BEQ, OP_BNE}) ? STATUS_Z : STATUS_C;
	assign branch_val_o = ir_i inside {OP_BEQ, OP_BCS, OP_SEC};
	assign sets_cv_o = ir_i inside {OP_ADC_IMM, OP_ADC_ABS, OP_SBC_IMM, OP_SBC_ABS};

endmodule

`default_nettype wire

//--- rtl/sequencer.sv
`default_nettype none
`timescale 1ns/100ps

module sequencer (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                rdy_i,
	input  cpu_pkg::op_class_t  op_class_i,
	input  cpu_pkg::addr_mode_t addr_mode_i,
	input  cpu_pkg::flag_sel_t  branch_flag_i,
	input  logic                branch_val_i,
	input  logic                sets_cv_i,
	input  cpu_pkg::data_t      status_i,
	output logic                ir_we_o,
	output logic                oper_lo_we_o,
	output logic                oper_hi_we_o,
	output logic                pc_inc_o,
	output logic                pc_load_o,
	output logic                pc_branch_o,
	output logic                reg_we_o,
	output logic                status_we_o,
	output logic                clc_o,
	output logic                sec_o,
	output logic                addr_sel_o,
	output logic                bus_we_o,
	output logic                halted_o
);
	import cpu_pkg::*;

	seq_state_t state_q;
	seq_state_t state_d;
	logic writes_reg;
	logic taken;
	logic is_flag;

	assign writes_reg = op_class_i inside {CLS_LOAD, CLS_ALU, CLS_INCDEC, CLS_TRANSFER};
	assign taken = (status_i[branch_flag_i] == branch_val_i);
	assign is_flag = (op_class_i == CLS_FLAG);

	// A stretched bus cycle holds the state
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			state_q <= S_FETCH;
		else if (rdy_i)
			state_q <= state_d;
	end

	// Register strobes only fire on a completing bus cycle
	always_comb begin
		state_d = state_q;
		ir_we_o = 1'b0;
		oper_lo_we_o = 1'b0;
		oper_hi_we_o = 1'b0;
		pc_inc_o = 1'b0;
		pc_load_o = 1'b0;
		pc_branch_o = 1'b0;
		reg_we_o = 1'b0;
		status_we_o = 1'b0;
		clc_o = 1'b0;
		sec_o = 1'b0;
		addr_sel_o = 1'b0;
		bus_we_o = 1'b0;
		halted_o = 1'b0;
		case (state_q)
			S_FETCH: begin
				ir_we_o = rdy_i;
				pc_inc_o = rdy_i;
				// Decode sees the opcode on the bus in this cycle
				if (op_class_i inside {CLS_HALT, CLS_ILLEGAL})
					state_d = S_HALTED;
				else if (addr_mode_i == AM_ABSOLUTE)
					state_d = S_OPER_LO;
				else
					state_d = S_DECODE;
			end
			S_DECODE: begin
				if (addr_mode_i == AM_RELATIVE) begin
					oper_lo_we_o = rdy_i;
					pc_inc_o = rdy_i;
					state_d = taken ? S_EXEC : S_FETCH;
				end else begin
					pc_inc_o = rdy_i && (addr_mode_i == AM_IMMEDIATE);
					reg_we_o = rdy_i && writes_reg;
					status_we_o = rdy_i && writes_reg && sets_cv_i;
					clc_o = rdy_i && is_flag && !branch_val_i;
					sec_o = rdy_i && is_flag && branch_val_i;
					state_d = S_FETCH;
				end
			end
			S_OPER_LO: begin
				oper_lo_we_o = rdy_i;
				pc_inc_o = rdy_i;
				state_d = S_OPER_HI;
			end
			S_OPER_HI: begin
				if (op_class_i == CLS_JUMP) begin
					pc_load_o = rdy_i;
					state_d = S_FETCH;
				end else begin
					oper_hi_we_o = rdy_i;
					pc_inc_o = rdy_i;
					state_d = (op_class_i == CLS_STORE) ? S_WRITE : S_EXEC;
				end
			end
			S_EXEC: begin
				if (addr_mode_i == AM_RELATIVE) begin
					pc_branch_o = rdy_i;
				end else begin
					addr_sel_o = 1'b1;
					reg_we_o = rdy_i && writes_reg;
					status_we_o = rdy_i && writes_reg && sets_cv_i;
				end
				state_d = S_FETCH;
			end
			S_WRITE: begin
				addr_sel_o = 1'b1;
				bus_we_o = 1'b1;
				state_d = S_FETCH;
			end
			S_HALTED: halted_o = 1'b1;
			default: state_d = S_HALTED;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/cpu.sv
`default_nettype none
`timescale 1ns/100ps

module cpu (
	input  logic           clk_i,
	input  logic           rst_n_i,
	input  logic           rdy_i,
	input  cpu_pkg::data_t data_i,
	output cpu_pkg::addr_t addr_o,
	output cpu_pkg::data_t data_o,
	output logic           we_o,
	output logic           dbg_o
);
	import cpu_pkg::*;

	data_t ir;
	data_t ir_dec;
	data_t oper_lo;
	data_t oper_hi;
	data_t a_q;
	data_t x_q;
	data_t y_q;
	data_t status;
	data_t alu_a;
	data_t alu_b;
	data_t alu_out;
	logic alu_cout;
	logic alu_ovf;
	logic alu_sign;
	logic alu_zero;
	addr_t pc_q;
	op_class_t op_class;
	alu_func_t alu_func;
	reg_sel_t reg_sel;
	reg_sel_t src_sel;
	addr_mode_t addr_mode;
	flag_sel_t branch_flag;
	logic branch_val;
	logic sets_cv;
	logic ir_we, oper_lo_we, oper_hi_we;
	logic pc_inc, pc_load, pc_branch;
	logic reg_we, status_we, clc, sec, addr_sel;

	function automatic data_t pick_reg(input reg_sel_t sel, input data_t ra,
			input data_t rx, input data_t ry);
		case (sel)
			REG_X: return rx;
			REG_Y: return ry;
			default: return ra;
		endcase
	endfunction

	always_ff @(posedge clk_i) begin
		if (ir_we)
			ir <= data_i;
		if (oper_lo_we)
			oper_lo <= data_i;
		if (oper_hi_we)
			oper_hi <= data_i;
	end

	// Opcode is decoded straight off the bus during fetch
	assign ir_dec = ir_we ? data_i : ir;

	// Loads pass the bus byte, inc/dec add one
	assign alu_a = (op_class == CLS_LOAD) ? data_i : pick_reg(src_sel, a_q, x_q, y_q);
	assign alu_b = (op_class == CLS_INCDEC) ? data_t'(1) : data_i;

	assign addr_o = addr_sel ? {oper_hi, oper_lo} : pc_q;
	assign data_o = pick_reg(reg_sel, a_q, x_q, y_q);

	alu i_alu (
		.func_i(alu_func), .a_i(alu_a), .b_i(alu_b), .carry_i(status[STATUS_C]),
		.result_o(alu_out), .carry_o(alu_cout), .ovf_o(alu_ovf),
		.sign_o(alu_sign), .zero_o(alu_zero)
	);

	cpu_regs i_regs (
		.clk_i, .rst_n_i, .reg_sel_i(reg_sel), .reg_we_i(reg_we), .reg_data_i(alu_out),
		.status_we_i(status_we), .carry_we_i(sets_cv), .ovf_we_i(sets_cv),
		.carry_i(alu_cout), .ovf_i(alu_ovf), .sign_i(alu_sign), .zero_i(alu_zero),
		.clc_i(clc), .sec_i(sec),
		.a_o(a_q), .x_o(x_q), .y_o(y_q), .status_o(status)
	);

	pc i_pc (
		.clk_i, .rst_n_i, .inc_i(pc_inc), .load_i(pc_load),
		.load_addr_i({data_i, oper_lo}), .branch_i(pc_branch), .offset_i(oper_lo),
		.pc_o(pc_q)
	);

	idec i_idec (
		.ir_i(ir_dec), .op_class_o(op_class), .alu_func_o(alu_func),
		.reg_sel_o(reg_sel), .src_sel_o(src_sel), .addr_mode_o(addr_mode),
		.branch_flag_o(branch_flag), .branch_val_o(branch_val), .sets_cv_o(sets_cv)
	);

	sequencer i_seq (
		.clk_i, .rst_n_i, .rdy_i, .op_class_i(op_class), .addr_mode_i(addr_mode),
		.branch_flag_i(branch_flag), .branch_val_i(branch_val), .sets_cv_i(sets_cv),
		.status_i(status),
		.ir_we_o(ir_we), .oper_lo_we_o(oper_lo_we), .oper_hi_we_o(oper_hi_we),
		.pc_inc_o(pc_inc), .pc_load_o(pc_load), .pc_branch_o(pc_branch),
		.reg_we_o(reg_we), .status_we_o(status_we), .clc_o(clc), .sec_o(sec),
		.addr_sel_o(addr_sel), .bus_we_o(we_o), .halted_o(dbg_o)
	);

endmodule

`default_nettype wire

//--- tests/cpu_mem_model.sv
`default_nettype none
`timescale 1ns/100ps

module cpu_mem_model (
	input  logic           clk_i,
	input  cpu_pkg::addr_t addr_i,
	input  cpu_pkg::data_t data_i,
	input  logic           we_i,
	input  logic           rdy_i,
	output cpu_pkg::data_t data_o
);
	import cpu_pkg::*;

	data_t mem [0:(1<<ADDR_W)-1];

	// Combinational read
	assign data_o = mem[addr_i];

	// A write lands only on the completing edge of the bus cycle
	always @(posedge clk_i) begin
		if (we_i && rdy_i)
			mem[addr_i] = data_i;
	end

endmodule

`default_nettype wire

//--- tests/tb_cpu.sv
`default_nettype none
`timescale 1ns/100ps

module tb_cpu;
	import cpu_pkg::*;

	logic clk;
	logic rst_n;
	logic rdy;
	logic stall_en;
	addr_t addr;
	data_t rdata;
	data_t wdata;
	logic we;
	logic dbg;
	addr_t pc_w;
	addr_t addr_held;
	data_t wdata_held;
	logic we_held;
	int seed;
	int errors;
	int tests_ok;
	int tests_bad;
	int err_at_start;

	cpu i_dut (
		.clk_i(clk), .rst_n_i(rst_n), .rdy_i(rdy), .data_i(rdata),
		.addr_o(addr), .data_o(wdata), .we_o(we), .dbg_o(dbg)
	);

	cpu_mem_model i_mem (
		.clk_i(clk), .addr_i(addr), .data_i(wdata), .we_i(we), .rdy_i(rdy), .data_o(rdata)
	);

	always #50 clk = ~clk;

	// Wait states on random cycles
	always @(negedge clk) begin
		if (stall_en)
			rdy <= (($random(seed) & 3) != 0);
		else
			rdy <= 1'b1;
	end

	function automatic data_t fill_byte(input addr_t a);
		return a[15:8] ^ a[7:0] ^ 8'h5c;
	endfunction

	// 6502 arithmetic and logic rules
	function automatic data_t alu_model(input data_t op, input data_t a, input data_t b,
			input logic c, output logic c_out);
		logic [8:0] s;
		c_out = c;
		case (op)
			OP_ADC_IMM: begin
				s = {1'b0, a} + {1'b0, b} + {8'd0, c};
				c_out = s[8];
				return s[7:0];
			end
			OP_SBC_IMM: begin
				// Borrow is the inverse of carry
				s = {1'b0, a} - {1'b0, b} - {8'd0, ~c};
				c_out = ~s[8];
				return s[7:0];
			end
			OP_AND_IMM: return a & b;
			OP_ORA_IMM: return a | b;
			default: return a ^ b;
		endcase
	endfunction

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// Bus outputs hold across an edge with rdy low
	always @(negedge clk) begin
		if (stall_en && !rdy) begin
			check_addr("addr_o", addr, addr_held);
			check_bit("we_o", we, we_held);
			if (we)
				check_data("data_o", wdata, wdata_held);
		end
		addr_held = addr;
		wdata_held = wdata;
		we_held = we;
	end

	task automatic new_prog();
		rst_n = 1'b0;
		for (int a = 0; a < (1 << ADDR_W); a++)
			i_mem.mem[addr_t'(a)] = fill_byte(addr_t'(a));
		pc_w = RESET_PC;
	endtask

	task automatic emit(input data_t b);
		i_mem.mem[pc_w] = b;
		pc_w++;
	endtask

	task automatic op2(input data_t op, input data_t v);
		emit(op);
		emit(v);
	endtask

	task automatic op3(input data_t op, input addr_t a);
		emit(op);
		emit(a[7:0]);
		emit(a[15:8]);
	endtask

	task automatic pulse_reset();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic run_prog();
		int n;
		pulse_reset();
		n = 0;
		while (!dbg && n < 5000) begin
			@(negedge clk);
			n++;
		end
		if (!dbg) begin
			$display("Timeout: the core never halted after %0d cycles", n);
			$display("** FAIL **");
			$finish;
		end
	endtask

	task automatic test_done(input string name);
		if (errors == err_at_start) begin
			$display("test %s: ok", name);
			tests_ok++;
		end else begin
			$display("test %s: failed", name);
			tests_bad++;
		end
		err_at_start = errors;
	endtask

	task automatic test_reset();
		@(negedge clk);
		rst_n = 1'b0;
		repeat (3) @(negedge clk);
		check_bit("we_o", we, 1'b0);
		check_bit("dbg_o", dbg, 1'b0);
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		#1;
		check_addr("addr_o", addr, RESET_PC);
		check_bit("we_o", we, 1'b0);
		check_bit("dbg_o", dbg, 1'b0);
		test_done("reset");
	endtask

	task automatic test_load_store();
		data_t v [6];
		for (int i = 0; i < 6; i++)
			v[i] = data_t'($random(seed));
		new_prog();
		i_mem.mem[16'h3100] = v[1];
		i_mem.mem[16'h3101] = v[3];
		i_mem.mem[16'h3102] = v[5];
		op2(OP_LDA_IMM, v[0]);
		op3(OP_STA_ABS, 16'h3000);
		op3(OP_LDX_ABS, 16'h3100);
		op3(OP_STX_ABS, 16'h3001);
		op2(OP_LDY_IMM, v[2]);
		op3(OP_STY_ABS, 16'h3002);
		op3(OP_LDA_ABS, 16'h3101);
		op3(OP_STA_ABS, 16'h3003);
		op2(OP_LDX_IMM, v[4]);
		op3(OP_STX_ABS, 16'h3004);
		op3(OP_LDY_ABS, 16'h3102);
		op3(OP_STY_ABS, 16'h3005);
		emit(OP_BRK);
		run_prog();
		for (int i = 0; i < 6; i++)
			check_data("mem[3000+i]", i_mem.mem[addr_t'(16'h3000 + i)], v[i]);
		test_done("load_store");
	endtask

	task automatic test_alu();
		data_t ops [5];
		data_t a;
		data_t b;
		data_t exp;
		logic c;
		logic c_exp;
		ops = '{OP_ADC_IMM, OP_SBC_IMM, OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM};
		for (int k = 0; k < 20; k++) begin
			a = data_t'($random(seed));
			b = data_t'($random(seed));
			c = k[1];
			exp = alu_model(ops[k % 5], a, b, c, c_exp);
			new_prog();
			emit(c ? OP_SEC : OP_CLC);
			op2(OP_LDA_IMM, a);
			if (k[0]) begin
				i_mem.mem[16'h3200] = b;
				op3(ops[k % 5] + 8'd4, 16'h3200);
			end else begin
				op2(ops[k % 5], b);
			end
			op3(OP_STA_ABS, 16'h3000);
			if (k[2]) begin
				op2(OP_LDA_IMM, 8'h01);
				op2(OP_BCS, 8'h02);
				op2(OP_LDA_IMM, 8'h00);
			end else begin
				op2(OP_LDA_IMM, 8'h00);
				op2(OP_BCC, 8'h02);
				op2(OP_LDA_IMM, 8'h01);
			end
			op3(OP_STA_ABS, 16'h3001);
			emit(OP_BRK);
			run_prog();
			check_data("alu result", i_mem.mem[16'h3000], exp);
			check_data("carry", i_mem.mem[16'h3001], {7'd0, c_exp});
		end
		test_done("alu");
	endtask

	task automatic test_registers();
		data_t r;
		r = data_t'($random(seed));
		new_prog();
		op2(OP_LDX_IMM, 8'hFF);
		emit(OP_INX);
		op3(OP_STX_ABS, 16'h3010);
		// Taken branch skips this store
		op2(OP_BEQ, 8'h05);
		op2(OP_LDA_IMM, 8'hAA);
		op3(OP_STA_ABS, 16'h3011);
		emit(OP_DEX);
		op3(OP_STX_ABS, 16'h3012);
		op2(OP_BEQ, 8'h05);
		op2(OP_LDA_IMM, 8'hAA);
		op3(OP_STA_ABS, 16'h3013);
		op2(OP_LDY_IMM, 8'h00);
		emit(OP_DEY);
		op3(OP_STY_ABS, 16'h3014);
		emit(OP_INY);
		op3(OP_STY_ABS, 16'h3015);
		op2(OP_BNE, 8'h05);
		op2(OP_LDA_IMM, 8'hAA);
		op3(OP_STA_ABS, 16'h3016);
		op2(OP_LDA_IMM, r);
		emit(OP_TAX);
		emit(OP_INX);
		emit(OP_TXA);
		op3(OP_STA_ABS, 16'h3017);
		emit(OP_TAY);
		emit(OP_DEY);
		emit(OP_DEY);
		emit(OP_TYA);
		op3(OP_STA_ABS, 16'h3018);
		emit(OP_BRK);
		run_prog();
		check_data("INX wrap", i_mem.mem[16'h3010], 8'h00);
		check_data("BEQ taken", i_mem.mem[16'h3011], fill_byte(16'h3011));
		check_data("DEX wrap", i_mem.mem[16'h3012], 8'hFF);
		check_data("BEQ not taken", i_mem.mem[16'h3013], 8'hAA);
		check_data("DEY wrap", i_mem.mem[16'h3014], 8'hFF);
		check_data("INY wrap", i_mem.mem[16'h3015], 8'h00);
		check_data("BNE not taken", i_mem.mem[16'h3016], 8'hAA);
		check_data("TAX/TXA", i_mem.mem[16'h3017], r + 8'd1);
		check_data("TAY/TYA", i_mem.mem[16'h3018], r - 8'd1);
		test_done("registers");
	endtask

	task automatic wait_prog(input data_t r, input data_t s, input data_t t);
		addr_t over;
		new_prog();
		emit(OP_CLC);
		op2(OP_LDA_IMM, r);
		op2(OP_ADC_IMM, s);
		op3(OP_STA_ABS, 16'h3020);
		over = pc_w + 16'd6;
		op3(OP_JMP_ABS, over);
		// X is still zero from reset here
		op3(OP_STX_ABS, 16'h3021);
		op2(OP_LDX_IMM, t);
		op3(OP_STX_ABS, 16'h3022);
		emit(OP_BRK);
	endtask

	task automatic test_wait_states();
		data_t r;
		data_t s;
		data_t t;
		r = data_t'($random(seed));
		s = data_t'($random(seed));
		t = data_t'($random(seed));
		wait_prog(r, s, t);
		run_prog();
		check_data("sum", i_mem.mem[16'h3020], r + s);
		check_data("STX", i_mem.mem[16'h3022], t);
		check_data("JMP skip", i_mem.mem[16'h3021], fill_byte(16'h3021));
		wait_prog(r, s, t);
		stall_en = 1'b1;
		run_prog();
		stall_en = 1'b0;
		check_data("sum stalled", i_mem.mem[16'h3020], r + s);
		check_data("STX stalled", i_mem.mem[16'h3022], t);
		check_data("JMP skip stalled", i_mem.mem[16'h3021], fill_byte(16'h3021));
		test_done("wait_states");
	endtask

	task automatic test_halt(input data_t stop_op);
		new_prog();
		op2(OP_LDA_IMM, 8'h01);
		op3(OP_STA_ABS, 16'h3030);
		emit(stop_op);
		op3(OP_STA_ABS, 16'h3031);
		run_prog();
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			check_bit("dbg_o", dbg, 1'b1);
			check_bit("we_o", we, 1'b0);
		end
		check_data("store before halt", i_mem.mem[16'h3030], 8'h01);
		check_data("store after halt", i_mem.mem[16'h3031], fill_byte(16'h3031));
		test_done(stop_op == OP_BRK ? "halt_brk" : "halt_illegal");
	endtask

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		rdy = 1'b1;
		stall_en = 1'b0;
		seed = 32'h0abe1b7a;
		errors = 0;
		tests_ok = 0;
		tests_bad = 0;
		err_at_start = 0;
		test_reset();
		test_load_store();
		test_alu();
		test_registers();
		test_wait_states();
		test_halt(OP_BRK);
		test_halt(8'h02);
		$display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- all.f
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/cpu_regs.sv
rtl/pc.sv
rtl/idec.sv
rtl/sequencer.sv
rtl/cpu.sv
tests/cpu_mem_model.sv
tests/tb_cpu.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_cpu -f all.f \
	--Mdir obj_dir -o sim_cpu > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/sim_cpu > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "Simulation reported failure, see sim.log"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
